// ==== Bender.yml ====
package:
  name: rv_ex

export_include_dirs:
  - logic

sources:
  - files:
      - logic/rv_ex_pkg.sv
      - logic/rv_ex_bus_if.sv
      - logic/rv_regfile.sv
      - logic/rv_ex_stage.sv
      - logic/rv_alu.sv
      - logic/rv_branch_resolve.sv
      - logic/rv_trap_regs.sv
      - logic/rv_ex_top.sv
  - target: simulation
    files:
      - verification/rv_ex_props.sv
      - verification/rv_ex_tb.sv

// ==== logic/rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu
    import rv_ex_pkg::*;
(
    ex_bus_if.exec bus,
    output word_t  o_result,
    output logic   o_cond_true
);

    // rv32i branch funct3 codes.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    word_t      alu_res;
    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = bus.op2[4:0];
    assign lt_s  = $signed(bus.op1) < $signed(bus.op2);
    assign lt_u  = bus.op1 < bus.op2;
    assign eq    = bus.op1 == bus.op2;

    // ------------------------------
    // operation
    // ------------------------------

    always_comb
    begin
        case (bus.alu_op)
            alu_add:    alu_res = bus.op1 + bus.op2;
            alu_sub:    alu_res = bus.op1 - bus.op2;
            alu_and:    alu_res = bus.op1 & bus.op2;
            alu_or:     alu_res = bus.op1 | bus.op2;
            alu_xor:    alu_res = bus.op1 ^ bus.op2;
            alu_slt:    alu_res = {31'b0, lt_s};
            alu_sltu:   alu_res = {31'b0, lt_u};
            alu_sll:    alu_res = bus.op1 << shamt;
            alu_srl:    alu_res = bus.op1 >> shamt;
            alu_sra:    alu_res = word_t'($signed(bus.op1) >>> shamt);
            alu_pass_b: alu_res = bus.op2;
            default:    alu_res = '0;
        endcase
    end

    // link value is the byte address of the next instruction.
    assign o_result = (bus.res_src == res_link) ? {bus.pc_next, 1'b0} : alu_res;

    // ------------------------------
    // branch condition
    // ------------------------------

    always_comb
    begin
        case (bus.funct3)
            F3_BEQ:  o_cond_true = eq;
            F3_BNE:  o_cond_true = !eq;
            F3_BLT:  o_cond_true = lt_s;
            F3_BGE:  o_cond_true = !lt_s;
            F3_BLTU: o_cond_true = lt_u;
            F3_BGEU: o_cond_true = !lt_u;
            default: o_cond_true = 1'b0;  // reserved codes never taken.
        endcase
    end

endmodule

// ==== logic/rv_branch_resolve.sv ====
`timescale 1ns/100ps

`include "rv_ex_params.svh"

module rv_branch_resolve
    import rv_ex_pkg::*;
(
    ex_bus_if.resolve bus,
    input  logic      i_cond_true,
    input  logic      i_clk,
    input  logic      i_arst_n,
    output logic      o_flush,
    output logic      o_redirect,
    output pc_t       o_redirect_pc,
    output logic      o_trap_take
);

    localparam logic [`RV_EX_ADDR_BITS-1:0] TRAP_VEC = `RV_EX_TRAP_VEC;

    logic taken;
    logic redirect;
    pc_t  target;

    assign taken = bus.is_jump | bus.is_mret | (bus.is_branch & i_cond_true);

    // a bubble has taken and branch_pred both low.
    assign redirect = bus.to_trap | (taken != bus.branch_pred);

    assign target = bus.to_trap ? TRAP_VEC[`RV_EX_ADDR_BITS-1:1] :
                    taken       ? bus.pc_target :
                    bus.pc_next;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_redirect <= 1'b0;
        else
            o_redirect <= redirect;
    end

    always_ff @(posedge i_clk)
    begin
        o_redirect_pc <= target;
    end

    assign o_flush     = redirect;     // kills the instruction entering ex.
    assign o_trap_take = bus.to_trap;

endmodule

// ==== logic/rv_ex_bus_if.sv ====
`timescale 1ns/100ps

interface ex_bus_if
    import rv_ex_pkg::*;
();

    word_t      op1;
    word_t      op2;
    alu_op_t    alu_op;
    logic [2:0] funct3;
    res_src_t   res_src;
    reg_idx_t   rd;
    logic       reg_write;
    pc_t        pc;
    pc_t        pc_next;
    pc_t        pc_target;
    logic       is_branch;
    logic       is_jump;        // jal or jalr.
    logic       is_mret;
    logic       to_trap;
    logic       branch_pred;

    modport stage
    (
        output op1, op2, alu_op, funct3, res_src, rd, reg_write,
        output pc, pc_next, pc_target,
        output is_branch, is_jump, is_mret, to_trap, branch_pred
    );

    modport exec
    (
        input op1, op2, alu_op, funct3, res_src, pc_next
    );

    modport resolve
    (
        input pc_next, pc_target, is_branch, is_jump, is_mret, to_trap, branch_pred
    );

endinterface

// ==== logic/rv_ex_params.svh ====
`ifndef RV_EX_PARAMS_SVH
`define RV_EX_PARAMS_SVH

// ------------------------------
// execute slice parameters
// ------------------------------

// instruction address width in bits.
`define RV_EX_ADDR_BITS 32

// machine trap handler entry.
`define RV_EX_TRAP_VEC 32'h0000_0100

// architectural register count, x0 included.
`define RV_EX_NREGS 32

`endif

// ==== logic/rv_ex_pkg.sv ====
`include "rv_ex_params.svh"

package rv_ex_pkg;

    // ------------------------------
    // widths
    // ------------------------------

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // pc without bit 0, instructions are halfword aligned.
    typedef logic [`RV_EX_ADDR_BITS-2:0] pc_t;

    // ------------------------------
    // control encodings
    // ------------------------------

    typedef enum logic [3:0]
    {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b      // used for lui style loads.
    } alu_op_t;

    typedef enum logic [1:0]
    {
        src_reg,
        src_imm_i,
        src_imm_j
    } op2_src_t;

    typedef enum logic [0:0]
    {
        res_alu,
        res_link        // return address for jal and jalr.
    } res_src_t;

endpackage

// ==== logic/rv_ex_stage.sv ====
`timescale 1ns/100ps

module rv_ex_stage
    import rv_ex_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_stall,
    input  logic       i_flush,
    input  pc_t        i_pc,
    input  pc_t        i_pc_next,
    input  logic       i_branch_pred,
    input  reg_idx_t   i_rs1,
    input  reg_idx_t   i_rs2,
    input  reg_idx_t   i_rd,
    input  word_t      i_imm_i,
    input  word_t      i_imm_j,
    input  logic [2:0] i_funct3,
    input  alu_op_t    i_alu_op,
    input  res_src_t   i_res_src,
    input  logic       i_op1_pc,
    input  op2_src_t   i_op2_src,
    input  logic       i_reg_write,
    input  logic       i_inst_jal,
    input  logic       i_inst_jalr,
    input  logic       i_inst_branch,
    input  logic       i_inst_mret,
    input  logic       i_to_trap,
    input  pc_t        i_ret_addr,
    input  word_t      i_reg1_data,
    input  word_t      i_reg2_data,
    output reg_idx_t   o_rs1,
    output reg_idx_t   o_rs2,
    ex_bus_if.stage    bus
);

    // control fields.
    logic       reg_write;
    logic       inst_jal;
    logic       inst_jalr;
    logic       inst_branch;
    logic       inst_mret;
    logic       to_trap;
    logic       branch_pred;

    // payload fields.
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_j;
    logic [2:0] funct3;
    alu_op_t    alu_op;
    res_src_t   res_src;
    logic       op1_pc;
    op2_src_t   op2_src;
    pc_t        pc;
    pc_t        pc_next;

    word_t      jalr_sum;

    // ------------------------------
    // decode to execute register
    // ------------------------------

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            reg_write   <= 1'b0;
            inst_jal    <= 1'b0;
            inst_jalr   <= 1'b0;
            inst_branch <= 1'b0;
            inst_mret   <= 1'b0;
            to_trap     <= 1'b0;
            branch_pred <= 1'b0;
        end
        else if (i_flush)
        begin
            reg_write   <= 1'b0;       // wrong path becomes a bubble.
            inst_jal    <= 1'b0;
            inst_jalr   <= 1'b0;
            inst_branch <= 1'b0;
            inst_mret   <= 1'b0;
            to_trap     <= 1'b0;
            branch_pred <= 1'b0;
        end
        else if (!i_stall)
        begin
            reg_write   <= i_reg_write;
            inst_jal    <= i_inst_jal;
            inst_jalr   <= i_inst_jalr;
            inst_branch <= i_inst_branch;
            inst_mret   <= i_inst_mret;
            to_trap     <= i_to_trap;
            branch_pred <= i_branch_pred;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_stall)
        begin
            rs1     <= i_rs1;
            rs2     <= i_rs2;
            rd      <= i_rd;
            imm_i   <= i_imm_i;
            imm_j   <= i_imm_j;
            funct3  <= i_funct3;
            alu_op  <= i_alu_op;
            res_src <= i_res_src;
            op1_pc  <= i_op1_pc;
            op2_src <= i_op2_src;
            pc      <= i_pc;
            pc_next <= i_pc_next;
        end
    end

    // ------------------------------
    // operands and target
    // ------------------------------

    assign bus.op1 = op1_pc ? {pc, 1'b0} : i_reg1_data;

    always_comb
    begin
        case (op2_src)
            src_imm_i: bus.op2 = imm_i;
            src_imm_j: bus.op2 = imm_j;
            default:   bus.op2 = i_reg2_data;
        endcase
    end

    // full sum first so an odd base and odd offset carry correctly.
    assign jalr_sum = i_reg1_data + imm_i;

    assign bus.pc_target = inst_mret ? i_ret_addr :
                           inst_jalr ? jalr_sum[31:1] :
                           pc + imm_j[31:1];

    assign bus.alu_op      = alu_op;
    assign bus.funct3      = funct3;
    assign bus.res_src     = res_src;
    assign bus.rd          = rd;
    assign bus.reg_write   = reg_write;
    assign bus.pc          = pc;
    assign bus.pc_next     = pc_next;
    assign bus.is_branch   = inst_branch;
    assign bus.is_jump     = inst_jal | inst_jalr;
    assign bus.is_mret     = inst_mret;
    assign bus.to_trap     = to_trap;
    assign bus.branch_pred = branch_pred;

    assign o_rs1 = rs1;        // regfile indexes.
    assign o_rs2 = rs2;

endmodule

// ==== logic/rv_ex_top.sv ====
`timescale 1ns/100ps

module rv_ex_top
    import rv_ex_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_arst_n,
    input  logic       i_stall,
    input  pc_t        i_pc,
    input  pc_t        i_pc_next,
    input  logic       i_branch_pred,
    input  reg_idx_t   i_rs1,
    input  reg_idx_t   i_rs2,
    input  reg_idx_t   i_rd,
    input  word_t      i_imm_i,
    input  word_t      i_imm_j,
    input  logic [2:0] i_funct3,
    input  alu_op_t    i_alu_op,
    input  res_src_t   i_res_src,
    input  logic       i_op1_pc,
    input  op2_src_t   i_op2_src,
    input  logic       i_reg_write,
    input  logic       i_inst_jal,
    input  logic       i_inst_jalr,
    input  logic       i_inst_branch,
    input  logic       i_inst_mret,
    input  logic       i_to_trap,
    output logic       o_wb_valid,
    output reg_idx_t   o_wb_rd,
    output word_t      o_wb_data,
    output logic       o_redirect,
    output pc_t        o_redirect_pc
);

    ex_bus_if bus ();

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    reg1_data;
    word_t    reg2_data;
    word_t    result;
    logic     cond_true;
    logic     flush;
    logic     trap_take;
    pc_t      ret_addr;

    rv_regfile u_regfile
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_wr_idx   (o_wb_rd),
        .i_wr_en    (o_wb_valid),
        .i_wr_data  (o_wb_data),
        .o_rs1_data (reg1_data),
        .o_rs2_data (reg2_data)
    );

    rv_ex_stage u_stage
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_flush       (flush),
        .i_pc          (i_pc),
        .i_pc_next     (i_pc_next),
        .i_branch_pred (i_branch_pred),
        .i_rs1         (i_rs1),
        .i_rs2         (i_rs2),
        .i_rd          (i_rd),
        .i_imm_i       (i_imm_i),
        .i_imm_j       (i_imm_j),
        .i_funct3      (i_funct3),
        .i_alu_op      (i_alu_op),
        .i_res_src     (i_res_src),
        .i_op1_pc      (i_op1_pc),
        .i_op2_src     (i_op2_src),
        .i_reg_write   (i_reg_write),
        .i_inst_jal    (i_inst_jal),
        .i_inst_jalr   (i_inst_jalr),
        .i_inst_branch (i_inst_branch),
        .i_inst_mret   (i_inst_mret),
        .i_to_trap     (i_to_trap),
        .i_ret_addr    (ret_addr),
        .i_reg1_data   (reg1_data),
        .i_reg2_data   (reg2_data),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .bus           (bus.stage)
    );

    rv_alu u_alu
    (
        .bus         (bus.exec),
        .o_result    (result),
        .o_cond_true (cond_true)
    );

    rv_branch_resolve u_resolve
    (
        .bus           (bus.resolve),
        .i_cond_true   (cond_true),
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .o_flush       (flush),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_trap_take   (trap_take)
    );

    rv_trap_regs u_trap_regs
    (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_trap_take (trap_take),
        .i_trap_pc   (bus.pc),
        .o_ret_addr  (ret_addr)
    );

    // ------------------------------
    // writeback register
    // ------------------------------

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            o_wb_valid <= 1'b0;
        else    // a stalled slot records a bubble.
            o_wb_valid <= bus.reg_write & !i_stall & !trap_take & (bus.rd != '0);
    end

    always_ff @(posedge i_clk)
    begin
        o_wb_rd   <= bus.rd;
        o_wb_data <= result;
    end

endmodule

// ==== logic/rv_regfile.sv ====
`timescale 1ns/100ps

`include "rv_ex_params.svh"

module rv_regfile
    import rv_ex_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_arst_n,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  reg_idx_t i_wr_idx,
    input  logic     i_wr_en,
    input  word_t    i_wr_data,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data
);

    word_t regs [1:`RV_EX_NREGS-1];    // no storage for x0.

    // read with bypass of the write in flight.
    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0)
            val = '0;
        else if (i_wr_en && (i_wr_idx == idx))
            val = i_wr_data;
        else
            val = regs[idx];
        return val;
    endfunction

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 1; i < `RV_EX_NREGS; i++)
                regs[i] <= '0;
        end
        else if (i_wr_en && (i_wr_idx != '0))
            regs[i_wr_idx] <= i_wr_data;
    end

    always_comb
    begin
        o_rs1_data = read_port(i_rs1);
        o_rs2_data = read_port(i_rs2);
    end

endmodule

// ==== logic/rv_trap_regs.sv ====
`timescale 1ns/100ps

module rv_trap_regs
    import rv_ex_pkg::*;
(
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_trap_take,
    input  pc_t  i_trap_pc,
    output pc_t  o_ret_addr
);

    // ------------------------------
    // saved return address
    // ------------------------------

    pc_t epc;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            epc <= '0;
        else if (i_trap_take)
            epc <= i_trap_pc;      // pc of the trapping instruction.
    end

    assign o_ret_addr = epc;       // mret target.

endmodule

// ==== tb.f ====
+incdir+logic
logic/rv_ex_pkg.sv
logic/rv_ex_bus_if.sv
logic/rv_regfile.sv
logic/rv_ex_stage.sv
logic/rv_alu.sv
logic/rv_branch_resolve.sv
logic/rv_trap_regs.sv
logic/rv_ex_top.sv
verification/rv_ex_props.sv
verification/rv_ex_tb.sv

// ==== verification/rv_ex_props.sv ====
`timescale 1ns/100ps

module rv_ex_props
    import rv_ex_pkg::*;
(
    input logic     i_clk,
    input logic     i_arst_n,
    input logic     i_wb_valid,
    input reg_idx_t i_wb_rd,
    input logic     i_redirect
);

    int fail_count = 0;     // failed assertions so far.

    // ------------------------------
    // writeback
    // ------------------------------

    wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wb_valid |-> (i_wb_rd != '0))
        else
        begin
            fail_count++;
            $error("writeback to x0 with o_wb_valid high");
        end

    // ------------------------------
    // redirect
    // ------------------------------

    quiet_after_reset: assert property (@(posedge i_clk)
        $rose(i_arst_n) |-> !i_redirect)
        else
        begin
            fail_count++;
            $error("o_redirect high in the first cycle after reset");
        end

    // flushed slot must come out as a bubble.
    wrong_path_bubble: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_redirect |=> (!i_wb_valid && !i_redirect))
        else
        begin
            fail_count++;
            $error("slot after a redirect was not a bubble");
        end

endmodule

bind rv_ex_top rv_ex_props u_props
(
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_wb_valid (o_wb_valid),
    .i_wb_rd    (o_wb_rd),
    .i_redirect (o_redirect)
);

// ==== verification/rv_ex_tb.sv ====
`timescale 1ns/100ps

`include "rv_ex_params.svh"

module rv_ex_tb
    import rv_ex_pkg::*;
();

    // reset, the six tests, then margin.
    localparam int    MAX_CYCLES = 10 + 33 + 11 + 80 + 11 + 9 + 8 + 100;
    localparam word_t TRAP_VEC   = `RV_EX_TRAP_VEC;

    typedef struct packed
    {
        logic     v;
        reg_idx_t rd;
        word_t    data;
        logic     redir;
        pc_t      rpc;
    } slot_exp_t;

    logic       i_clk;
    logic       i_arst_n;
    logic       i_stall;
    pc_t        i_pc;
    pc_t        i_pc_next;
    logic       i_branch_pred;
    reg_idx_t   i_rs1;
    reg_idx_t   i_rs2;
    reg_idx_t   i_rd;
    word_t      i_imm_i;
    word_t      i_imm_j;
    logic [2:0] i_funct3;
    alu_op_t    i_alu_op;
    res_src_t   i_res_src;
    logic       i_op1_pc;
    op2_src_t   i_op2_src;
    logic       i_reg_write;
    logic       i_inst_jal;
    logic       i_inst_jalr;
    logic       i_inst_branch;
    logic       i_inst_mret;
    logic       i_to_trap;
    logic       o_wb_valid;
    reg_idx_t   o_wb_rd;
    word_t      o_wb_data;
    logic       o_redirect;
    pc_t        o_redirect_pc;

    word_t      model_regs [0:`RV_EX_NREGS-1];
    pc_t        model_epc;
    slot_exp_t  exp_q [$];      // results due two edges after issue.
    logic       squash = 1'b0;
    pc_t        slot_pc;
    int         cycles = 0;
    int         checks = 0;
    int         errors = 0;
    int         test_errors = 0;
    int         tests_run = 0;

    rv_ex_top dut0 (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
        word_t r;
        case (op)
            alu_add:    r = a + b;
            alu_sub:    r = a - b;
            alu_and:    r = a & b;
            alu_or:     r = a | b;
            alu_xor:    r = a ^ b;
            alu_slt:    r = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   r = {31'b0, a < b};
            alu_sll:    r = a << b[4:0];
            alu_srl:    r = a >> b[4:0];
            alu_sra:    r = word_t'($signed(a) >>> b[4:0]);
            alu_pass_b: r = b;
            default:    r = '0;
        endcase
        return r;
    endfunction

    function automatic logic cond_model(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ------------------------------
    // compare tasks
    // ------------------------------

    task automatic compare_word(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_idx(input string what, input reg_idx_t got, input reg_idx_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_pc(input string what, input pc_t got, input pc_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            test_errors++;
            $display("mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ------------------------------
    // slot drivers
    // ------------------------------

    task automatic bubble_fields();
        i_stall       <= 1'b0;
        i_pc          <= '0;
        i_pc_next     <= '0;
        i_branch_pred <= 1'b0;
        i_rs1         <= '0;
        i_rs2         <= '0;
        i_rd          <= '0;
        i_imm_i       <= '0;
        i_imm_j       <= '0;
        i_funct3      <= '0;
        i_alu_op      <= alu_add;
        i_res_src     <= res_alu;
        i_op1_pc      <= 1'b0;
        i_op2_src     <= src_reg;
        i_reg_write   <= 1'b0;
        i_inst_jal    <= 1'b0;
        i_inst_jalr   <= 1'b0;
        i_inst_branch <= 1'b0;
        i_inst_mret   <= 1'b0;
        i_to_trap     <= 1'b0;
    endtask

    task automatic begin_slot(input logic stall);
        @(posedge i_clk);
        slot_pc = pc_t'($urandom);
        bubble_fields();
        i_stall   <= stall;
        i_pc      <= slot_pc;
        i_pc_next <= slot_pc + 31'd2;
    endtask

    task automatic check_front();
        slot_exp_t e;
        e = exp_q.pop_front();
        compare_flag("o_wb_valid", o_wb_valid, e.v);
        if (e.v)
        begin
            compare_idx("o_wb_rd", o_wb_rd, e.rd);
            compare_word("o_wb_data", o_wb_data, e.data);
        end
        compare_flag("o_redirect", o_redirect, e.redir);
        if (e.redir)
            compare_pc("o_redirect_pc", o_redirect_pc, e.rpc);
    endtask

    task automatic finish_slot(input logic v, input reg_idx_t rd, input word_t data,
                               input logic redir, input pc_t rpc);
        slot_exp_t e;
        e.v     = v & !squash;      // wrong path slot leaves no trace.
        e.rd    = rd;
        e.data  = data;
        e.redir = redir & !squash;
        e.rpc   = rpc;
        @(negedge i_clk);
        check_front();
        if (e.v)
            model_regs[rd] = data;
        squash = e.redir;
        exp_q.push_back(e);
    endtask

    task automatic bubble();
        begin_slot(1'b0);
        finish_slot(1'b0, '0, '0, 1'b0, '0);
    endtask

    task automatic stall_slot();
        slot_exp_t held;
        begin_slot(1'b1);
        @(negedge i_clk);
        check_front();
        // the held instruction retires one slot later.
        held = exp_q.pop_back();
        exp_q.push_back('0);
        exp_q.push_back(held);
    endtask

    task automatic issue_alu(input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
                             input word_t imm, input alu_op_t op, input op2_src_t src,
                             input logic op1_pc, input logic trap);
        word_t a;
        word_t b;
        begin_slot(1'b0);
        a = op1_pc ? {slot_pc, 1'b0} : model_regs[rs1];
        b = (src == src_reg) ? model_regs[rs2] : imm;
        i_rd        <= rd;
        i_rs1       <= rs1;
        i_rs2       <= rs2;
        i_imm_i     <= (src == src_imm_j) ? ~imm : imm;    // unselected immediate inverted.
        i_imm_j     <= (src == src_imm_j) ? imm : ~imm;
        i_alu_op    <= op;
        i_op2_src   <= src;
        i_op1_pc    <= op1_pc;
        i_reg_write <= 1'b1;
        i_to_trap   <= trap;
        finish_slot(rd != '0 && !trap, rd, alu_model(op, a, b), trap, TRAP_VEC[31:1]);
    endtask

    task automatic issue_branch(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                                input word_t imm, input logic pred);
        logic  taken;
        word_t tgt;
        begin_slot(1'b0);
        taken = cond_model(f3, model_regs[rs1], model_regs[rs2]);
        tgt   = {slot_pc, 1'b0} + imm;
        i_inst_branch <= 1'b1;
        i_funct3      <= f3;
        i_rs1         <= rs1;
        i_rs2         <= rs2;
        i_imm_j       <= imm;
        i_alu_op      <= alu_sub;
        i_branch_pred <= pred;
        finish_slot(1'b0, '0, '0, taken != pred, taken ? tgt[31:1] : slot_pc + 31'd2);
    endtask

    task automatic issue_jump(input logic jalr, input reg_idx_t rd, input reg_idx_t rs1,
                              input word_t imm, input logic pred);
        word_t tgt;
        begin_slot(1'b0);
        tgt = jalr ? model_regs[rs1] + imm : {slot_pc, 1'b0} + imm;
        i_inst_jal    <= !jalr;
        i_inst_jalr   <= jalr;
        i_rd          <= rd;
        i_rs1         <= rs1;
        i_imm_i       <= jalr ? imm : ~imm;
        i_imm_j       <= jalr ? ~imm : imm;
        i_res_src     <= res_link;
        i_reg_write   <= 1'b1;
        i_branch_pred <= pred;
        finish_slot(rd != '0, rd, {slot_pc + 31'd2, 1'b0}, !pred, tgt[31:1]);
    endtask

    task automatic issue_mret(input logic pred);
        begin_slot(1'b0);
        i_inst_mret   <= 1'b1;
        i_branch_pred <= pred;
        finish_slot(1'b0, '0, '0, !pred, model_epc);
    endtask

    task automatic end_test(input string name);
        bubble();
        bubble();
        $display("test %s done, %0d errors", name, test_errors);
        tests_run++;
        test_errors = 0;
    endtask

    // ------------------------------
    // tests
    // ------------------------------

    task automatic alu_forms();
        reg_idx_t rd;
        for (int r = 1; r <= 8; r++)
            issue_alu(reg_idx_t'(r), '0, '0, $urandom, alu_pass_b, src_imm_i, 1'b0, 1'b0);
        for (int k = 0; k < 11; k++)
        begin
            rd = reg_idx_t'(9 + k % 6);
            issue_alu(rd, reg_idx_t'($urandom_range(1, 8)), reg_idx_t'($urandom_range(1, 8)),
                      '0, alu_op_t'(k), src_reg, 1'b0, 1'b0);
            issue_alu(rd, reg_idx_t'($urandom_range(1, 8)), '0,
                      $urandom, alu_op_t'(k), src_imm_i, 1'b0, 1'b0);
        end
        issue_alu(5'd15, '0, '0, $urandom, alu_add, src_imm_j, 1'b1, 1'b0);    // pc relative.
        end_test("alu_forms");
    endtask

    task automatic back_to_back();
        reg_idx_t src;
        issue_alu(5'd16, '0, '0, $urandom, alu_pass_b, src_imm_i, 1'b0, 1'b0);
        src = 5'd16;
        for (int k = 0; k < 8; k++)
        begin
            issue_alu(reg_idx_t'(17 + k), src, reg_idx_t'($urandom_range(1, 8)),
                      '0, alu_op_t'(k % 5), src_reg, 1'b0, 1'b0);
            src = reg_idx_t'(17 + k);   // next one reads this result.
        end
        end_test("back_to_back");
    endtask

    task automatic branches();
        word_t a;
        word_t b;
        for (int s = 0; s < 3; s++)
        begin
            // equal, random, then sign bit flipped.
            a = $urandom;
            b = (s == 0) ? a : (s == 1) ? word_t'($urandom) : a ^ 32'h8000_0000;
            issue_alu(5'd20, '0, '0, a, alu_pass_b, src_imm_i, 1'b0, 1'b0);
            issue_alu(5'd21, '0, '0, b, alu_pass_b, src_imm_i, 1'b0, 1'b0);
            for (int f = 0; f < 8; f++)
            begin
                if (f == 2 || f == 3)
                    continue;
                for (int p = 0; p < 2; p++)
                begin
                    issue_branch(f[2:0], 5'd20, 5'd21, word_t'($urandom) & 32'hffff_fffe, p == 1);
                    issue_alu(5'd25, 5'd20, 5'd21, '0, alu_add, src_reg, 1'b0, 1'b0);
                end
            end
        end
        end_test("branches");
    endtask

    task automatic jumps();
        issue_alu(5'd22, '0, '0, $urandom, alu_pass_b, src_imm_i, 1'b0, 1'b0);
        for (int p = 0; p < 2; p++)
        begin
            issue_jump(1'b0, 5'd26, '0, word_t'($urandom) & 32'hffff_fffe, p == 1);
            issue_alu(5'd24, 5'd22, '0, $urandom, alu_add, src_imm_i, 1'b0, 1'b0);
            issue_jump(1'b1, 5'd26, 5'd22, $urandom, p == 1);
            issue_alu(5'd24, 5'd22, '0, $urandom, alu_add, src_imm_i, 1'b0, 1'b0);
        end
        end_test("jumps");
    endtask

    task automatic trap_and_return();
        bubble();
        issue_alu(5'd27, 5'd1, 5'd2, '0, alu_add, src_reg, 1'b0, 1'b1);
        model_epc = slot_pc;
        issue_alu(5'd26, 5'd1, 5'd2, '0, alu_sub, src_reg, 1'b0, 1'b0);    // wrong path.
        issue_alu(5'd28, 5'd27, '0, '0, alu_add, src_reg, 1'b0, 1'b0);
        issue_mret(1'b0);
        issue_alu(5'd26, 5'd1, 5'd2, '0, alu_sub, src_reg, 1'b0, 1'b0);
        issue_mret(1'b1);
        end_test("trap_and_return");
    endtask

    task automatic stall_and_x0();
        issue_alu(5'd29, 5'd3, 5'd4, '0, alu_xor, src_reg, 1'b0, 1'b0);
        stall_slot();
        stall_slot();
        issue_alu(5'd30, 5'd29, '0, '0, alu_add, src_reg, 1'b0, 1'b0);
        issue_alu('0, '0, '0, $urandom, alu_pass_b, src_imm_i, 1'b0, 1'b0);
        issue_alu(5'd30, '0, '0, $urandom, alu_add, src_imm_i, 1'b0, 1'b0);
        end_test("stall_and_x0");
    endtask

    initial
    begin
        void'($urandom(32'hb810));
        i_arst_n <= 1'b0;
        bubble_fields();
        for (int r = 0; r < `RV_EX_NREGS; r++)
            model_regs[r] = '0;
        repeat (10) @(posedge i_clk);
        i_arst_n <= 1'b1;
        exp_q.push_back('0);    // pipeline is empty after reset.
        exp_q.push_back('0);
        alu_forms();
        back_to_back();
        branches();
        jumps();
        trap_and_return();
        stall_and_x0();
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, checks, errors, dut0.u_props.fail_count);
        if (errors == 0 && dut0.u_props.fail_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
